// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_mem_stage
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+hw
hw/lc3b_types.sv
hw/lc3b_ctrl_pkg.sv
hw/mem_if.sv
hw/mem_control.sv
hw/mem_datapath.sv
hw/data_sram.sv
hw/lc3b_mem_stage.sv
tb/tb_mem_stage.sv

// ==== hw/data_sram.sv ====
`timescale 1ns/100ps
`include "lc3b_defs.svh"

module data_sram (
    input logic   clk,
    input logic   rst_n,
    mem_if.slave  mem
);
    import lc3b_types::*;

    localparam int ADDR_W = $clog2(`LC3B_MEM_WORDS);

    lc3b_word          ram [`LC3B_MEM_WORDS];
    logic [ADDR_W-1:0] word_addr;
    logic [3:0]        dly_cnt;
    logic              req_new;

    initial ram = '{default: '0};

    assign word_addr = mem.address[ADDR_W:1];
    assign req_new   = (mem.read || mem.write) && (dly_cnt == 4'd0);  // first cycle only.
    assign mem.resp  = (dly_cnt == 4'd1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dly_cnt <= 4'd0;
        else if (req_new)
            dly_cnt <= 4'(`LC3B_MEM_RESP_DLY);
        else if (dly_cnt != 4'd0)
            dly_cnt <= dly_cnt - 4'd1;
    end

    always_ff @(posedge clk)
    begin
        if (req_new && mem.read)
            mem.rdata <= ram[word_addr];
        if (req_new && mem.write)
        begin
            if (mem.wmask[0])
                ram[word_addr][7:0] <= mem.wdata[7:0];
            if (mem.wmask[1])
                ram[word_addr][15:8] <= mem.wdata[15:8];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem.read && mem.write));

endmodule : data_sram

// ==== hw/lc3b_ctrl_pkg.sv ====
package lc3b_ctrl_pkg;

    typedef enum logic [2:0] {
        MARMUX_ALU,
        MARMUX_PC,
        MARMUX_BR_ADD,
        MARMUX_RDATA,
        MARMUX_TRAP
    } marmux_sel_t;

    typedef enum logic [1:0] {
        MDRMUX_SR1,
        MDRMUX_RDATA,
        MDRMUX_SR1_BYTE  // low byte copied to both halves.
    } mdrmux_sel_t;

    typedef enum logic [2:0] {
        REGFILEMUX_ALU,
        REGFILEMUX_MDR,
        REGFILEMUX_BR_ADD,
        REGFILEMUX_PC,
        REGFILEMUX_SHIFT,
        REGFILEMUX_LDB
    } regfilemux_sel_t;

    typedef struct packed {
        marmux_sel_t     marmux_sel;
        mdrmux_sel_t     mdrmux_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            load_mar;
        logic            load_mdr;
        logic            load_cc;
        logic            mem_read;
        logic            mem_write;
        logic [1:0]      mem_byte_enable;
    } lc3b_control_word;

endpackage : lc3b_ctrl_pkg

// ==== hw/lc3b_defs.svh ====
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// data word and address width.
`define LC3B_WORD_W 16

// sram depth in words.
`define LC3B_MEM_WORDS 256

// cycles from first request sample to resp.
`define LC3B_MEM_RESP_DLY 1

`endif

// ==== hw/lc3b_mem_stage.sv ====
`timescale 1ns/100ps
`include "lc3b_defs.svh"

module lc3b_mem_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [`LC3B_WORD_W-1:0] instruction,
    input  logic [`LC3B_WORD_W-1:0] alu_out,
    input  logic [`LC3B_WORD_W-1:0] pc_out,
    input  logic [`LC3B_WORD_W-1:0] br_add_out,
    input  logic [`LC3B_WORD_W-1:0] sr1_out,
    output logic                    done,
    output logic [`LC3B_WORD_W-1:0] result,
    output logic                    br_en
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_instr        instr_q;
    lc3b_instr        cur_instr;
    lc3b_control_word ctrl;
    logic             addr_lsb;

    mem_if mem_bus ();

    // instruction only valid with start, held here for the rest.
    always_ff @(posedge clk)
    begin
        if (start)
            instr_q <= instruction;
    end

    assign cur_instr = start ? lc3b_instr'(instruction) : instr_q;

    mem_control u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .instruction (cur_instr),
        .resp        (mem_bus.resp),
        .addr_lsb    (addr_lsb),
        .ctrl        (ctrl),
        .done        (done)
    );

    mem_datapath u_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .alu_out        (alu_out),
        .pc_out         (pc_out),
        .br_add_out     (br_add_out),
        .sr1_out        (sr1_out),
        .instruction    (cur_instr),
        .mem            (mem_bus.master),
        .regfilemux_out (result),
        .br_en          (br_en),
        .addr_lsb       (addr_lsb)
    );

    data_sram u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus.slave)
    );

endmodule : lc3b_mem_stage

// ==== hw/lc3b_types.sv ====
`include "lc3b_defs.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;  // n, z, p.

    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_LDB  = 4'b0010,
        OP_STB  = 4'b0011,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_SHF  = 4'b1101,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } lc3b_opcode;

    // base + offset form, also used by shf and br.
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    base;
        logic [5:0] offset6;
    } lc3b_mem_fmt;

    typedef struct packed {
        lc3b_opcode opcode;
        logic [3:0] zero;
        logic [7:0] trapvect8;
    } lc3b_trap_fmt;

    typedef union packed {
        lc3b_mem_fmt  mem;
        lc3b_trap_fmt trap;
    } lc3b_instr;

endpackage : lc3b_types

// ==== hw/mem_control.sv ====
`timescale 1ns/100ps

module mem_control (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  lc3b_types::lc3b_instr            instruction,
    input  logic                             resp,
    input  logic                             addr_lsb,
    output lc3b_ctrl_pkg::lc3b_control_word  ctrl,
    output logic                             done
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_MEM,
        S_FINISH
    } state_t;

    state_t     state;
    state_t     next_state;
    lc3b_opcode opcode;
    logic       is_load;
    logic       is_store;

    assign opcode   = instruction.mem.opcode;
    assign is_load  = (opcode == OP_LDR) || (opcode == OP_LDB) || (opcode == OP_TRAP);
    assign is_store = (opcode == OP_STR) || (opcode == OP_STB);
    assign done     = (state == S_FINISH);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:   if (start) next_state = (is_load || is_store) ? S_ADDR : S_FINISH;
            S_ADDR:   next_state = S_MEM;
            S_MEM:    if (resp) next_state = S_FINISH;
            S_FINISH: next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        ctrl.marmux_sel      = MARMUX_ALU;
        ctrl.mdrmux_sel      = MDRMUX_SR1;
        ctrl.regfilemux_sel  = REGFILEMUX_ALU;
        ctrl.mem_byte_enable = 2'b11;
        case (state)
            S_ADDR:
            begin
                ctrl.load_mar = 1'b1;
                if (opcode == OP_TRAP)
                    ctrl.marmux_sel = MARMUX_TRAP;
                ctrl.load_mdr = is_store;
                if (opcode == OP_STB)
                    ctrl.mdrmux_sel = MDRMUX_SR1_BYTE;
            end
            S_MEM:
            begin
                ctrl.mem_read  = is_load;
                ctrl.mem_write = is_store;
                if (opcode == OP_STB)
                    ctrl.mem_byte_enable = addr_lsb ? 2'b10 : 2'b01;  // one lane only.
                if (is_load)
                begin
                    ctrl.mdrmux_sel = MDRMUX_RDATA;
                    ctrl.load_mdr   = resp;
                end
            end
            S_FINISH:
            begin
                case (opcode)
                    OP_LDR, OP_TRAP: ctrl.regfilemux_sel = REGFILEMUX_MDR;
                    OP_LDB:          ctrl.regfilemux_sel = REGFILEMUX_LDB;
                    OP_LEA:          ctrl.regfilemux_sel = REGFILEMUX_BR_ADD;
                    OP_SHF:          ctrl.regfilemux_sel = REGFILEMUX_SHIFT;
                    default:         ctrl.regfilemux_sel = REGFILEMUX_ALU;
                endcase
                ctrl.load_cc = (opcode == OP_LDR) || (opcode == OP_LDB) ||
                               (opcode == OP_LEA) || (opcode == OP_SHF);
            end
            default:
            begin
                ctrl.load_mar = 1'b0;
            end
        endcase
    end

    // caller must wait for done before the next start.
    assert property (@(posedge clk) disable iff (!rst_n) start |-> state == S_IDLE);

    assert property (@(posedge clk) disable iff (!rst_n) resp |-> state == S_MEM);

endmodule : mem_control

// ==== hw/mem_datapath.sv ====
`timescale 1ns/100ps

module mem_datapath (
    input  logic                            clk,
    input  logic                            rst_n,
    input  lc3b_ctrl_pkg::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word            alu_out,
    input  lc3b_types::lc3b_word            pc_out,
    input  lc3b_types::lc3b_word            br_add_out,
    input  lc3b_types::lc3b_word            sr1_out,
    input  lc3b_types::lc3b_instr           instruction,
    mem_if.master                           mem,
    output lc3b_types::lc3b_word            regfilemux_out,
    output logic                            br_en,
    output logic                            addr_lsb
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_word   mar;
    lc3b_word   mdr;
    lc3b_word   marmux_out;
    lc3b_word   mdrmux_out;
    lc3b_word   trap_addr;
    lc3b_word   shift_out;
    lc3b_word   ldb_out;
    lc3b_nzp    gencc_out;
    lc3b_nzp    cc;
    logic [3:0] imm4;
    logic       shift_a;
    logic       shift_d;

    assign mem.read    = ctrl.mem_read;
    assign mem.write   = ctrl.mem_write;
    assign mem.wmask   = ctrl.mem_byte_enable;
    assign mem.address = mar;
    assign mem.wdata   = mdr;
    assign addr_lsb    = mar[0];

    assign trap_addr = lc3b_word'({instruction.trap.trapvect8, 1'b0});  // vector table is word sized.

    always_comb
    begin
        case (ctrl.marmux_sel)
            MARMUX_ALU:    marmux_out = alu_out;
            MARMUX_PC:     marmux_out = pc_out;
            MARMUX_BR_ADD: marmux_out = br_add_out;
            MARMUX_RDATA:  marmux_out = mem.rdata;
            MARMUX_TRAP:   marmux_out = trap_addr;
            default:       marmux_out = '0;
        endcase
    end

    always_comb
    begin
        case (ctrl.mdrmux_sel)
            MDRMUX_SR1:      mdrmux_out = sr1_out;
            MDRMUX_RDATA:    mdrmux_out = mem.rdata;
            MDRMUX_SR1_BYTE: mdrmux_out = {2{sr1_out[7:0]}};
            default:         mdrmux_out = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_mar)
            mar <= marmux_out;
        if (ctrl.load_mdr)
            mdr <= mdrmux_out;
    end

    // shf fields sit in offset6.
    assign imm4    = instruction.mem.offset6[3:0];
    assign shift_d = instruction.mem.offset6[4];
    assign shift_a = instruction.mem.offset6[5];

    always_comb
    begin
        if (!shift_d)
            shift_out = sr1_out << imm4;
        else if (shift_a)
            shift_out = lc3b_word'($signed(sr1_out) >>> imm4);
        else
            shift_out = sr1_out >> imm4;
    end

    assign ldb_out = lc3b_word'(mar[0] ? mdr[15:8] : mdr[7:0]);

    always_comb
    begin
        case (ctrl.regfilemux_sel)
            REGFILEMUX_ALU:    regfilemux_out = alu_out;
            REGFILEMUX_MDR:    regfilemux_out = mdr;
            REGFILEMUX_BR_ADD: regfilemux_out = br_add_out;
            REGFILEMUX_PC:     regfilemux_out = pc_out;
            REGFILEMUX_SHIFT:  regfilemux_out = shift_out;
            REGFILEMUX_LDB:    regfilemux_out = ldb_out;
            default:           regfilemux_out = '0;
        endcase
    end

    assign gencc_out[2] = regfilemux_out[15];
    assign gencc_out[1] = ~|regfilemux_out;
    assign gencc_out[0] = ~regfilemux_out[15] && |regfilemux_out;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cc <= 3'b010;  // z.
        else if (ctrl.load_cc)
            cc <= gencc_out;
    end

    assign br_en = |(cc & instruction.mem.dest);

    // request must not move until the sram answers.
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem.read || mem.write) && !mem.resp |=> $stable(mem.address) && $stable(mem.wdata));

endmodule : mem_datapath

// ==== hw/mem_if.sv ====
`timescale 1ns/100ps

interface mem_if;
    import lc3b_types::*;

    logic       read;
    logic       write;
    logic [1:0] wmask;
    lc3b_word   address;  // byte address.
    lc3b_word   wdata;
    lc3b_word   rdata;
    logic       resp;

    modport master (
        output read, write, wmask, address, wdata,
        input  rdata, resp
    );

    modport slave (
        input  read, write, wmask, address, wdata,
        output rdata, resp
    );

endinterface : mem_if

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/100ps
`include "lc3b_defs.svh"

module tb_mem_stage;

    localparam logic [3:0] OPC_BR   = 4'b0000;
    localparam logic [3:0] OPC_LDB  = 4'b0010;
    localparam logic [3:0] OPC_STB  = 4'b0011;
    localparam logic [3:0] OPC_LDR  = 4'b0110;
    localparam logic [3:0] OPC_STR  = 4'b0111;
    localparam logic [3:0] OPC_SHF  = 4'b1101;
    localparam logic [3:0] OPC_LEA  = 4'b1110;
    localparam logic [3:0] OPC_TRAP = 4'b1111;

    localparam int N_RW        = 8;
    localparam int N_BYTE      = 6;
    localparam int N_TRAP      = 6;
    localparam int N_LEA       = 4;
    localparam int N_SHF       = 10;
    localparam int N_INSTR     = 1 + 3 * N_RW + 5 * N_BYTE + 2 * N_TRAP + 2 * N_LEA + 2 * N_SHF;
    localparam int CYCLE_LIMIT = 40 * N_INSTR + 8;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [15:0] instruction;
    logic [15:0] alu_out;
    logic [15:0] pc_out;
    logic [15:0] br_add_out;
    logic [15:0] sr1_out;
    logic        done;
    logic [15:0] result;
    logic        br_en;

    // expectations for the instruction in flight.
    logic        slow_op;
    logic        check_res;
    logic [15:0] exp_res;
    logic        check_br;
    logic        exp_br;

    logic [15:0] model [`LC3B_MEM_WORDS];
    logic [2:0]  model_cc;
    int          result_errs;
    int          timing_errs;
    int          branch_errs;
    int          cycle_cnt;

    lc3b_mem_stage dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .instruction (instruction),
        .alu_out     (alu_out),
        .pc_out      (pc_out),
        .br_add_out  (br_add_out),
        .sr1_out     (sr1_out),
        .done        (done),
        .result      (result),
        .br_en       (br_en)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [2:0] nzp_of(input logic [15:0] value);
        if (value[15])
            return 3'b100;
        if (value == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    // ctl holds the offset6 bits a, d and imm4.
    function automatic logic [15:0] shift_word(input logic [15:0] value, input logic [5:0] ctl);
        logic [15:0] res;
        res = value;
        for (int k = 0; k < int'(ctl[3:0]); k++)
        begin
            if (!ctl[4])
                res = {res[14:0], 1'b0};
            else
                res = {ctl[5] & res[15], res[15:1]};  // one place per step.
        end
        return res;
    endfunction

    task automatic issue(
        input logic [15:0] instr,
        input logic [15:0] alu,
        input logic [15:0] sr1,
        input logic [15:0] br_add,
        input logic        want_res,
        input logic [15:0] expect_val
    );
        logic [3:0] opc;
        opc = instr[15:12];
        @(negedge clk);
        instruction = instr;
        alu_out     = alu;
        sr1_out     = sr1;
        br_add_out  = br_add;
        pc_out      = 16'($urandom);
        slow_op     = (opc == OPC_LDR) || (opc == OPC_LDB) || (opc == OPC_STR) ||
                      (opc == OPC_STB) || (opc == OPC_TRAP);
        check_res   = want_res;
        exp_res     = expect_val;
        check_br    = (opc == OPC_BR);
        exp_br      = |(instr[11:9] & model_cc);
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
        if ((opc == OPC_LDR) || (opc == OPC_LDB) || (opc == OPC_LEA) || (opc == OPC_SHF))
            model_cc = nzp_of(expect_val);
    endtask

    task automatic branch_test();
        logic [2:0] nzp;
        nzp = 3'($urandom);
        issue({OPC_BR, nzp, 9'($urandom)}, 16'($urandom), 16'($urandom), 16'($urandom),
              1'b0, 16'h0000);
    endtask

    // memory ops finish 4 cycles after start, the rest after 1.
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (slow_op ? $past(start, 4) : $past(start, 1)))
    else
    begin
        timing_errs++;
        $display("done pulsed without a start at the expected distance at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) $past(start && slow_op, 4) |-> done)
    else
    begin
        timing_errs++;
        $display("memory instruction gave no done 4 cycles after start at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) $past(start, 1) && !slow_op |-> done)
    else
    begin
        timing_errs++;
        $display("single-cycle instruction gave no done after start at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n) done && check_res |-> result == exp_res)
    else
    begin
        result_errs++;
        $display("** Error: result = %h, expected %h", $sampled(result), $sampled(exp_res));
    end

    assert property (@(posedge clk) disable iff (!rst_n) done && check_br |-> br_en == exp_br)
    else
    begin
        branch_errs++;
        $display("** Error: br_en = %h, expected %h", $sampled(br_en), $sampled(exp_br));
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: stimulus still running after %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] br_add;
        logic [7:0]  idx;
        logic [5:0]  ctl;
        rst_n       = 1'b0;
        start       = 1'b0;
        instruction = 16'h0000;
        alu_out     = 16'h0000;
        pc_out      = 16'h0000;
        br_add_out  = 16'h0000;
        sr1_out     = 16'h0000;
        slow_op     = 1'b0;
        check_res   = 1'b0;
        exp_res     = 16'h0000;
        check_br    = 1'b0;
        exp_br      = 1'b0;
        model_cc    = 3'b010;  // z after reset.
        result_errs = 0;
        timing_errs = 0;
        branch_errs = 0;
        cycle_cnt   = 0;
        for (int i = 0; i < `LC3B_MEM_WORDS; i++)
            model[i] = 16'h0000;
        void'($urandom(32'h53b3_8f74));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        branch_test();

        for (int i = 0; i < N_RW; i++)
        begin
            addr = 16'($urandom % 512) & 16'h01fe;
            data = 16'($urandom);
            issue({OPC_STR, 3'd1, 3'd2, 6'($urandom)}, addr, data, 16'($urandom), 1'b0, 16'h0);
            model[addr[8:1]] = data;
            issue({OPC_LDR, 3'd3, 3'd2, 6'($urandom)}, addr, 16'($urandom), 16'($urandom),
                  1'b1, model[addr[8:1]]);
            branch_test();
        end

        // a full word first, so the untouched byte is known.
        for (int i = 0; i < N_BYTE; i++)
        begin
            addr = 16'($urandom % 512);
            addr[0] = i[0];
            data = 16'($urandom);
            issue({OPC_STR, 3'd1, 3'd2, 6'($urandom)}, addr & 16'hfffe, data, 16'($urandom),
                  1'b0, 16'h0);
            model[addr[8:1]] = data;
            data = 16'($urandom);
            issue({OPC_STB, 3'd1, 3'd2, 6'($urandom)}, addr, data, 16'($urandom), 1'b0, 16'h0);
            if (addr[0])
                model[addr[8:1]][15:8] = data[7:0];
            else
                model[addr[8:1]][7:0] = data[7:0];
            issue({OPC_LDR, 3'd4, 3'd2, 6'($urandom)}, addr & 16'hfffe, 16'($urandom),
                  16'($urandom), 1'b1, model[addr[8:1]]);
            issue({OPC_LDB, 3'd5, 3'd2, 6'($urandom)}, addr, 16'($urandom), 16'($urandom), 1'b1,
                  {8'h00, addr[0] ? model[addr[8:1]][15:8] : model[addr[8:1]][7:0]});
            branch_test();
        end

        for (int i = 0; i < N_TRAP; i++)
        begin
            idx  = 8'($urandom);
            data = 16'($urandom);
            issue({OPC_STR, 3'd1, 3'd2, 6'($urandom)}, {7'h00, idx, 1'b0}, data, 16'($urandom),
                  1'b0, 16'h0);
            model[idx] = data;
            issue({OPC_TRAP, 4'h0, idx}, 16'($urandom), 16'($urandom), 16'($urandom),
                  1'b1, model[idx]);
        end

        for (int i = 0; i < N_LEA; i++)
        begin
            br_add = (i == 0) ? 16'h0000 : 16'($urandom);
            issue({OPC_LEA, 3'($urandom), 9'($urandom)}, 16'($urandom), 16'($urandom), br_add,
                  1'b1, br_add);
            branch_test();
        end

        for (int i = 0; i < N_SHF; i++)
        begin
            data = 16'($urandom);
            ctl  = 6'($urandom);
            issue({OPC_SHF, 3'd3, 3'd4, ctl}, 16'($urandom), data, 16'($urandom), 1'b1,
                  shift_word(data, ctl));
            branch_test();
        end

        repeat (4) @(negedge clk);
        $display("errors: result %0d, timing %0d, branch %0d",
                 result_errs, timing_errs, branch_errs);
        if (result_errs + timing_errs + branch_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule : tb_mem_stage
